// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - design
    files:
      - design/dcache_pkg.sv
      - design/cache_way.sv
      - design/dcache_ctrl.sv
      - design/load_select.sv
      - design/dcache_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/dcache_sva.sv
      - sim/dcache_tb.sv

// File: design/cache_way.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module cache_way (
    input  wire                         clock,
    input  wire                         reset,
    input  wire dcache_pkg::index_t     lookup_index,
    input  wire dcache_pkg::tag_t       lookup_tag,
    input  wire                         we,
    input  wire dcache_pkg::line_mask_t wr_mask,
    input  wire dcache_pkg::line_t      wr_line,
    input  wire                         wr_dirty,
    output logic                        hit,
    output logic                        valid,
    output logic                        dirty,
    output dcache_pkg::tag_t            tag,
    output dcache_pkg::line_t           rd_line
);
    import dcache_pkg::*;

    tag_t                tag_mem  [`DC_SETS];
    line_t               data_mem [`DC_SETS];
    logic [`DC_SETS-1:0] valid_q;
    logic [`DC_SETS-1:0] dirty_q;
    logic                full_write;

    // a full-line write is an install, anything less is a store hit
    assign full_write = &wr_mask;

    assign valid = valid_q[lookup_index];
    assign dirty = dirty_q[lookup_index];
    assign tag   = tag_mem[lookup_index];
    assign hit   = valid && (tag == lookup_tag);

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we) begin
            if (full_write) begin
                valid_q[lookup_index] <= 1'b1;
                dirty_q[lookup_index] <= wr_dirty;   // clean fill or merged store
            end else begin
                dirty_q[lookup_index] <= dirty_q[lookup_index] | wr_dirty;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (we && full_write) begin
            tag_mem[lookup_index] <= lookup_tag;
        end
    end

    // bit-masked line write, read port registered
    always_ff @(posedge clock) begin
        if (we) begin
            data_mem[lookup_index] <= (data_mem[lookup_index] & ~wr_mask)
                                    | (wr_line & wr_mask);
        end
        rd_line <= data_mem[lookup_index];   // old data on a same-edge write
    end

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_ctrl (
    input  wire                         clock,
    input  wire                         reset,
    input  wire                         valid,
    input  wire                         op,
    input  wire dcache_pkg::addr_t      addr,
    input  wire dcache_pkg::strb_t      wstrb,
    input  wire dcache_pkg::word_t      wdata,
    input  wire                         rd_rdy,
    input  wire                         ret_valid,
    input  wire                         ret_last,
    input  wire dcache_pkg::word_t      ret_data,
    input  wire                         wr_rdy,
    input  wire dcache_pkg::way_vec_t   way_hit,
    input  wire dcache_pkg::way_vec_t   way_valid,
    input  wire dcache_pkg::way_vec_t   way_dirty,
    input  wire dcache_pkg::tag_t       way_tag [`DC_WAYS],
    input  wire dcache_pkg::line_t      way_line [`DC_WAYS],
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic                        rd_req,
    output dcache_pkg::addr_t           rd_addr,
    output logic                        wr_req,
    output dcache_pkg::addr_t           wr_addr,
    output dcache_pkg::line_t           wr_data,
    output dcache_pkg::index_t          lookup_index,
    output dcache_pkg::tag_t            lookup_tag,
    output dcache_pkg::way_vec_t        way_we,
    output dcache_pkg::line_mask_t      wr_mask,
    output dcache_pkg::line_t           wr_line,
    output logic                        wr_dirty,
    output dcache_pkg::line_t           fill_line,
    output logic                        fill_sel,
    output logic                        word_hi
);
    import dcache_pkg::*;

    ctrl_state_t state;
    tag_t        in_tag;
    index_t      in_index;
    offset_t     in_offset;
    tag_t        buf_tag;
    index_t      buf_index;
    logic        buf_op;
    line_t       buf_line;
    line_mask_t  buf_mask;
    word_t       strb_bits;
    word_t       shifted_data;
    word_t       shifted_mask;
    line_t       store_line;
    line_mask_t  store_mask;
    line_t       fill_merge;
    logic        accept;
    way_vec_t    victim;
    way_vec_t    victim_next;
    logic        victim_dirty;

    // invalid way first, then clean way 0, clean way 1, else dirty way 0
    function automatic way_vec_t pick_victim(way_vec_t v, way_vec_t d);
        if (!v[0]) begin
            return 2'b01;
        end else if (!v[1]) begin
            return 2'b10;
        end else if (!d[0]) begin
            return 2'b01;
        end else if (!d[1]) begin
            return 2'b10;
        end
        return 2'b01;
    endfunction

    assign in_tag    = addr[`DC_OFFSET_BITS+`DC_INDEX_BITS +: `DC_TAG_BITS];
    assign in_index  = addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign in_offset = addr[`DC_OFFSET_BITS-1:0];

    assign addr_ok = (state == IDLE);
    assign accept  = valid && addr_ok;

    // incoming address while idle, buffered miss otherwise
    assign lookup_index = (state == IDLE) ? in_index : buf_index;
    assign lookup_tag   = (state == IDLE) ? in_tag : buf_tag;

    always_comb begin
        for (int b = 0; b < `DC_WORD_BITS/8; b++) begin
            strb_bits[8*b +: 8] = {8{wstrb[b]}};
        end
    end

    // byte shift inside the word, then pick the line half
    assign shifted_data = wdata << {in_offset[2:0], 3'b000};
    assign shifted_mask = strb_bits << {in_offset[2:0], 3'b000};
    assign store_line = in_offset[3] ? {shifted_data, {`DC_WORD_BITS{1'b0}}}
                                     : {{`DC_WORD_BITS{1'b0}}, shifted_data};
    assign store_mask = in_offset[3] ? {shifted_mask, {`DC_WORD_BITS{1'b0}}}
                                     : {{`DC_WORD_BITS{1'b0}}, shifted_mask};

    assign fill_merge   = (buf_line & buf_mask) | (fill_line & ~buf_mask);
    assign victim_next  = pick_victim(way_valid, way_dirty);
    assign victim_dirty = |(victim_next & way_valid & way_dirty);

    always_comb begin
        way_we   = '0;
        wr_mask  = store_mask;
        wr_line  = store_line;
        wr_dirty = 1'b1;
        if (state == INSTALL) begin
            way_we   = victim;
            wr_mask  = '1;
            wr_line  = fill_merge;
            wr_dirty = buf_op;   // a store miss installs dirty
        end else if (accept && op) begin
            way_we = way_hit;    // zero on a store miss
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= IDLE;
            rd_req   <= 1'b0;
            wr_req   <= 1'b0;
            data_ok  <= 1'b0;
            fill_sel <= 1'b0;
            victim   <= '0;
        end else begin
            data_ok  <= 1'b0;
            fill_sel <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        if (|way_hit) begin
                            data_ok <= 1'b1;
                        end else begin
                            rd_req <= 1'b1;
                            state  <= MISS_REQ;
                        end
                    end
                end
                MISS_REQ: begin
                    if (rd_rdy) begin
                        rd_req <= 1'b0;
                        state  <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (ret_valid && ret_last) begin
                        victim <= victim_next;
                        if (victim_dirty) begin
                            wr_req <= 1'b1;
                            state  <= WRITEBACK;
                        end else begin
                            state <= INSTALL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (wr_rdy) begin
                        wr_req <= 1'b0;
                        state  <= INSTALL;
                    end
                end
                INSTALL: begin
                    data_ok  <= 1'b1;
                    fill_sel <= 1'b1;   // load word comes from the refilled line
                    state    <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            buf_tag   <= in_tag;
            buf_index <= in_index;
            buf_op    <= op;
            buf_line  <= store_line;
            buf_mask  <= op ? store_mask : '0;
            word_hi   <= in_offset[3];
            rd_addr   <= {in_tag, in_index, {`DC_OFFSET_BITS{1'b0}}};
        end
        if (state == MISS_WAIT && ret_valid) begin
            if (ret_last) begin
                fill_line[`DC_LINE_BITS-1 -: `DC_WORD_BITS] <= ret_data;
            end else begin
                fill_line[`DC_WORD_BITS-1:0] <= ret_data;
            end
        end
        // victim line is already registered from the buffered index
        if (state == MISS_WAIT && ret_valid && ret_last && victim_dirty) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (victim_next[w]) begin
                    wr_data <= way_line[w];
                    wr_addr <= {way_tag[w], buf_index, {`DC_OFFSET_BITS{1'b0}}};
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// address split is tag | index | offset
`define DC_OFFSET_BITS 4     // 16-byte line
`define DC_INDEX_BITS  7
`define DC_TAG_BITS    21

`define DC_WAYS        2
`define DC_SETS        128   // one entry per index value

`define DC_LINE_BITS   128
`define DC_WORD_BITS   64    // cpu word and memory beat

`endif

// File: design/dcache_pkg.sv
`default_nettype none
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_BITS+`DC_INDEX_BITS+`DC_OFFSET_BITS-1:0] addr_t;
    typedef logic [`DC_TAG_BITS-1:0]      tag_t;
    typedef logic [`DC_INDEX_BITS-1:0]    index_t;
    typedef logic [`DC_OFFSET_BITS-1:0]   offset_t;
    typedef logic [`DC_WORD_BITS-1:0]     word_t;
    typedef logic [`DC_WORD_BITS/8-1:0]   strb_t;   // one bit per byte
    typedef logic [`DC_LINE_BITS-1:0]     line_t;
    typedef logic [`DC_LINE_BITS-1:0]     line_mask_t;  // 1 = write this bit
    typedef logic [`DC_WAYS-1:0]          way_vec_t;

    typedef enum logic [2:0] {
        IDLE,
        MISS_REQ,
        MISS_WAIT,
        WRITEBACK,
        INSTALL
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_top (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    valid,
    input  wire                    op,
    input  wire dcache_pkg::addr_t addr,
    input  wire dcache_pkg::strb_t wstrb,
    input  wire dcache_pkg::word_t wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output dcache_pkg::word_t      rdata,
    output logic                   rd_req,
    output dcache_pkg::addr_t      rd_addr,
    input  wire                    rd_rdy,
    input  wire                    ret_valid,
    input  wire                    ret_last,
    input  wire dcache_pkg::word_t ret_data,
    output logic                   wr_req,
    output dcache_pkg::addr_t      wr_addr,
    output dcache_pkg::line_t      wr_data,
    input  wire                    wr_rdy
);
    import dcache_pkg::*;

    index_t     lookup_index;
    tag_t       lookup_tag;
    way_vec_t   way_we;
    line_mask_t wr_mask;
    line_t      wr_line;
    logic       wr_dirty;
    way_vec_t   way_hit;
    way_vec_t   way_valid;
    way_vec_t   way_dirty;
    tag_t       way_tag [`DC_WAYS];
    line_t      way_line [`DC_WAYS];
    line_t      fill_line;
    logic       fill_sel;
    logic       word_hi;

    dcache_ctrl ctrl_i (
        .clock        (clock),
        .reset        (reset),
        .valid        (valid),
        .op           (op),
        .addr         (addr),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .wr_rdy       (wr_rdy),
        .way_hit      (way_hit),
        .way_valid    (way_valid),
        .way_dirty    (way_dirty),
        .way_tag      (way_tag),
        .way_line     (way_line),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rd_req       (rd_req),
        .rd_addr      (rd_addr),
        .wr_req       (wr_req),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .way_we       (way_we),
        .wr_mask      (wr_mask),
        .wr_line      (wr_line),
        .wr_dirty     (wr_dirty),
        .fill_line    (fill_line),
        .fill_sel     (fill_sel),
        .word_hi      (word_hi)
    );

    // every way sees the same lookup and write data, only we differs
    for (genvar i = 0; i < `DC_WAYS; i++) begin : way_g
        cache_way way_i (
            .clock        (clock),
            .reset        (reset),
            .lookup_index (lookup_index),
            .lookup_tag   (lookup_tag),
            .we           (way_we[i]),
            .wr_mask      (wr_mask),
            .wr_line      (wr_line),
            .wr_dirty     (wr_dirty),
            .hit          (way_hit[i]),
            .valid        (way_valid[i]),
            .dirty        (way_dirty[i]),
            .tag          (way_tag[i]),
            .rd_line      (way_line[i])
        );
    end

    load_select load_i (
        .clock     (clock),
        .reset     (reset),
        .way_hit   (way_hit),
        .way_line  (way_line),
        .fill_line (fill_line),
        .fill_sel  (fill_sel),
        .word_hi   (word_hi),
        .data      (rdata)
    );

endmodule

`default_nettype wire

// File: design/load_select.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module load_select (
    input  wire                       clock,
    input  wire                       reset,
    input  wire dcache_pkg::way_vec_t way_hit,
    input  wire dcache_pkg::line_t    way_line [`DC_WAYS],
    input  wire dcache_pkg::line_t    fill_line,
    input  wire                       fill_sel,
    input  wire                       word_hi,
    output dcache_pkg::word_t         data
);
    import dcache_pkg::*;

    way_vec_t hit_q;
    line_t    sel_line;

    // aligned with the registered rd_line of the ways
    always_ff @(posedge clock) begin
        if (reset) begin
            hit_q <= '0;
        end else begin
            hit_q <= way_hit;
        end
    end

    always_comb begin
        sel_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            sel_line = sel_line | (way_line[w] & {`DC_LINE_BITS{hit_q[w]}});   // one-hot
        end
        if (fill_sel) begin
            sel_line = fill_line;
        end
    end

    assign data = word_hi ? sel_line[`DC_LINE_BITS-1 -: `DC_WORD_BITS]
                          : sel_line[`DC_WORD_BITS-1:0];

endmodule

`default_nettype wire

// File: sim/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
    input wire                       clock,
    input wire                       reset,
    input wire                       valid,
    input wire                       addr_ok,
    input wire                       data_ok,
    input wire                       rd_req,
    input wire dcache_pkg::addr_t    rd_addr,
    input wire                       rd_rdy,
    input wire                       wr_req,
    input wire dcache_pkg::addr_t    wr_addr,
    input wire dcache_pkg::line_t    wr_data,
    input wire                       wr_rdy,
    input wire dcache_pkg::way_vec_t way_hit
);

    int fail_count = 0;

    reset_state: assert property (@(posedge clock)
        $fell(reset) |-> addr_ok && !rd_req && !wr_req && !data_ok)
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

    // request held until the memory takes it
    rd_hold: assert property (@(posedge clock) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else begin
            $error("rd_req or rd_addr changed before rd_rdy");
            fail_count++;
        end

    rd_once: assert property (@(posedge clock) disable iff (reset)
        rd_req && rd_rdy |=> !rd_req)
        else begin
            $error("rd_req stayed high after its handshake");
            fail_count++;
        end

    wr_hold: assert property (@(posedge clock) disable iff (reset)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else begin
            $error("write-back request changed before wr_rdy");
            fail_count++;
        end

    rd_wr_apart: assert property (@(posedge clock) disable iff (reset)
        !(rd_req && wr_req))
        else begin
            $error("rd_req and wr_req high together");
            fail_count++;
        end

    rd_from_miss: assert property (@(posedge clock) disable iff (reset)
        $rose(rd_req) |-> $past(valid && addr_ok && !(|way_hit)))
        else begin
            $error("rd_req rose without a missing request");
            fail_count++;
        end

    miss_blocks: assert property (@(posedge clock) disable iff (reset)
        valid && addr_ok && !(|way_hit) |=> !addr_ok)
        else begin
            $error("addr_ok high right after a miss");
            fail_count++;
        end

    busy_no_data: assert property (@(posedge clock) disable iff (reset)
        !addr_ok |-> !data_ok)
        else begin
            $error("data_ok while a miss is still open");
            fail_count++;
        end

    release_with_data: assert property (@(posedge clock) disable iff (reset)
        $rose(addr_ok) |-> data_ok)
        else begin
            $error("addr_ok returned without data_ok");
            fail_count++;
        end

endmodule

bind dcache_top dcache_sva sva_i (
    .clock   (clock),
    .reset   (reset),
    .valid   (valid),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_rdy  (rd_rdy),
    .wr_req  (wr_req),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_rdy  (wr_rdy),
    .way_hit (way_hit)
);

`default_nettype wire

// File: sim/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_defs.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int PERIOD       = 100;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_WORDS    = 4096;   // tags 0..15 over all sets
    localparam int N_MISS_HIT   = 4;
    localparam int N_RANDOM     = 40 + 32;   // random mix, then readback sweep
    localparam int N_SAME_SET   = 3;
    localparam int N_PRESSURE   = 40;
    localparam int N_CLEAN      = 4;
    localparam int N_REQUESTS   = N_MISS_HIT + N_RANDOM + N_SAME_SET + N_PRESSURE + N_CLEAN;

    logic     clock;
    logic     reset;
    logic     valid;
    logic     op;
    addr_t    addr;
    strb_t    wstrb;
    word_t    wdata;
    logic     addr_ok;
    logic     data_ok;
    word_t    rdata;
    logic     rd_req;
    addr_t    rd_addr;
    logic     rd_rdy;
    logic     ret_valid;
    logic     ret_last;
    word_t    ret_data;
    logic     wr_req;
    addr_t    wr_addr;
    line_t    wr_data;
    logic     wr_rdy;

    logic [31:0] lcg_state;
    logic [31:0] delay_state;     // separate stream for the memory model
    word_t    mem [MEM_WORDS];      // memory behind the cache
    word_t    shadow [MEM_WORDS];   // what every load should see
    logic     sh_valid [`DC_WAYS][`DC_SETS];
    logic     sh_dirty [`DC_WAYS][`DC_SETS];
    tag_t     sh_tag [`DC_WAYS][`DC_SETS];

    logic     req_hit;
    word_t    req_word;
    addr_t    req_line;
    logic     req_wb;
    addr_t    req_wb_addr;
    line_t    req_wb_data;
    logic     pend_valid;
    logic     pend_load;
    word_t    pend_word;
    addr_t    pend_line;
    logic     wb_pend;
    addr_t    wb_addr;
    line_t    wb_data;

    int       errors = 0;
    int       test_mark = 0;
    int       tests_run = 0;
    int       tests_failed = 0;

    dcache_top dut_i (
        .clock     (clock),
        .reset     (reset),
        .valid     (valid),
        .op        (op),
        .addr      (addr),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_step(lcg_state);
        return lcg_state;
    endfunction

    function automatic int next_gap();
        delay_state = lcg_step(delay_state);
        return int'(delay_state >> 30);
    endfunction

    function automatic addr_t make_addr(input int tag, input int index, input int word);
        return {tag_t'(tag), index_t'(index), word[0], 3'b000};
    endfunction

    function automatic int word_slot(input addr_t a);
        return int'(a[14:3]);
    endfunction

    function automatic int total_errors();
        return errors + dut_i.sva_i.fail_count;
    endfunction

    initial begin
        clock = 1'b0;
        forever #(PERIOD/2) clock = ~clock;
    end

    // memory side, ready held low for 0..3 cycles
    task automatic serve_read();
        int gap;
        int base;
        gap = next_gap();
        repeat (gap) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        base = word_slot(rd_addr);
        rd_rdy = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        rd_rdy    = 1'b0;
        ret_valid = 1'b1;
        ret_data  = mem[base];   // low half first
        @(posedge clock);
        #DRIVE_DELAY;
        ret_last = 1'b1;
        ret_data = mem[base + 1];
        @(posedge clock);
        #DRIVE_DELAY;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
    endtask

    task automatic serve_write();
        int gap;
        int base;
        gap = next_gap();
        repeat (gap) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        base = word_slot(wr_addr);
        mem[base]     = wr_data[`DC_WORD_BITS-1:0];
        mem[base + 1] = wr_data[`DC_LINE_BITS-1 -: `DC_WORD_BITS];
        wr_rdy = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        wr_rdy = 1'b0;
    endtask

    initial begin
        forever begin
            @(posedge clock);
            #DRIVE_DELAY;
            if (rd_req) begin
                serve_read();
            end else if (wr_req) begin
                serve_write();
            end
        end
    end

    // updates the shadow state in request order, then drives one request
    task automatic issue(input logic is_store, input addr_t a, input strb_t s, input word_t d);
        int   idx;
        int   slot;
        int   hit_w;
        int   vic;
        tag_t t;
        while (!addr_ok) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        t     = a[31 -: `DC_TAG_BITS];
        idx   = a[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
        slot  = word_slot(a);
        hit_w = -1;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (sh_valid[w][idx] && sh_tag[w][idx] == t) begin
                hit_w = w;
            end
        end
        req_hit  = (hit_w >= 0);
        req_word = shadow[slot];
        req_line = {t, index_t'(idx), 4'b0000};
        req_wb   = 1'b0;
        if (hit_w >= 0) begin
            if (is_store) begin
                sh_dirty[hit_w][idx] = 1'b1;
            end
        end else begin
            if (!sh_valid[0][idx]) begin
                vic = 0;
            end else if (!sh_valid[1][idx]) begin
                vic = 1;
            end else if (!sh_dirty[0][idx]) begin
                vic = 0;
            end else if (!sh_dirty[1][idx]) begin
                vic = 1;
            end else begin
                vic = 0;
            end
            if (sh_valid[vic][idx] && sh_dirty[vic][idx]) begin
                req_wb      = 1'b1;
                req_wb_addr = {sh_tag[vic][idx], index_t'(idx), 4'b0000};
                req_wb_data = {shadow[word_slot(req_wb_addr) + 1], shadow[word_slot(req_wb_addr)]};
            end
            sh_valid[vic][idx] = 1'b1;
            sh_tag[vic][idx]   = t;
            sh_dirty[vic][idx] = is_store;
        end
        if (is_store) begin
            for (int b = 0; b < `DC_WORD_BITS/8; b++) begin
                if (s[b]) begin
                    shadow[slot][8*b +: 8] = d[8*b +: 8];
                end
            end
        end
        valid = 1'b1;
        op    = is_store;
        addr  = a;
        wstrb = s;
        wdata = d;
        @(posedge clock);
        #DRIVE_DELAY;
        valid = 1'b0;
    endtask

    task automatic random_burst(input int count, input int idx_base);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = next_rand();
            issue(r[31], make_addr(r[29:28], idx_base + r[25:24], r[20]), r[15:8],
                  {next_rand(), next_rand()});
        end
    endtask

    task automatic end_test(input string name);
        int fails;
        while (!addr_ok || pend_valid) begin
            @(posedge clock);
            #DRIVE_DELAY;
        end
        @(posedge clock);
        #DRIVE_DELAY;
        fails = total_errors() - test_mark;
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d failing checks)", tests_run, name,
                 (fails == 0) ? "passed" : "failed", fails);
        test_mark = total_errors();
    endtask

    // open request and open write-back, as seen at each edge
    always @(posedge clock) begin
        if (reset) begin
            pend_valid <= 1'b0;
            wb_pend    <= 1'b0;
        end else begin
            if (data_ok) begin
                pend_valid <= 1'b0;
            end
            if (valid && addr_ok) begin
                pend_valid <= 1'b1;
                pend_load  <= !op;
                pend_word  <= req_word;
                pend_line  <= req_line;
                if (req_wb) begin
                    wb_pend <= 1'b1;
                    wb_addr <= req_wb_addr;
                    wb_data <= req_wb_data;
                end
            end
            if (wr_req && wr_rdy) begin
                wb_pend <= 1'b0;
            end
        end
    end

    hit_latency: assert property (@(posedge clock) disable iff (reset)
        valid && addr_ok && req_hit |=> data_ok)
        else begin
            $display("hit was not answered one cycle after acceptance");
            errors++;
        end

    load_value: assert property (@(posedge clock) disable iff (reset)
        data_ok && pend_load |-> rdata == pend_word)
        else begin
            $display("FAIL rdata got %h expected %h", $sampled(rdata), $sampled(pend_word));
            errors++;
        end

    answer_once: assert property (@(posedge clock) disable iff (reset)
        data_ok |-> pend_valid)
        else begin
            $display("data_ok came without an open request");
            errors++;
        end

    rd_address: assert property (@(posedge clock) disable iff (reset)
        rd_req |-> rd_addr == pend_line)
        else begin
            $display("FAIL rd_addr got %h expected %h", $sampled(rd_addr), $sampled(pend_line));
            errors++;
        end

    wb_allowed: assert property (@(posedge clock) disable iff (reset)
        wr_req |-> wb_pend)
        else begin
            $display("write-back issued although the victim was clean or invalid");
            errors++;
        end

    wb_address: assert property (@(posedge clock) disable iff (reset)
        wr_req && wr_rdy |-> wr_addr == wb_addr)
        else begin
            $display("FAIL wr_addr got %h expected %h", $sampled(wr_addr), $sampled(wb_addr));
            errors++;
        end

    wb_line: assert property (@(posedge clock) disable iff (reset)
        wr_req && wr_rdy |-> wr_data == wb_data)
        else begin
            $display("FAIL wr_data got %h expected %h", $sampled(wr_data), $sampled(wb_data));
            errors++;
        end

    wb_done: assert property (@(posedge clock) disable iff (reset)
        data_ok |-> !wb_pend)
        else begin
            $display("dirty victim was not written back before the install");
            errors++;
        end

    initial begin
        #(PERIOD * (RESET_CYCLES + 40 * N_REQUESTS));
        $display("timeout: requests did not complete in the allowed time");
        $display("Something failed");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        valid     = 1'b0;
        op        = 1'b0;
        addr      = '0;
        wstrb     = '0;
        wdata     = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        req_hit   = 1'b0;
        req_word  = '0;
        req_line  = '0;
        req_wb    = 1'b0;
        lcg_state = 32'h1ece16c4;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = {next_rand(), next_rand()};
            shadow[i] = mem[i];
        end
        delay_state = next_rand();
        for (int s = 0; s < `DC_SETS; s++) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                sh_valid[w][s] = 1'b0;
                sh_dirty[w][s] = 1'b0;
                sh_tag[w][s]   = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        end_test("reset state");

        for (int i = 0; i < N_MISS_HIT; i++) begin
            issue(1'b0, make_addr(1, 5, i), '0, '0);   // first one misses
        end
        end_test("load miss then hits");

        random_burst(40, 0);
        for (int t = 0; t < 4; t++) begin
            for (int s = 0; s < 4; s++) begin
                issue(1'b0, make_addr(t, s, 0), '0, '0);
                issue(1'b0, make_addr(t, s, 1), '0, '0);
            end
        end
        end_test("strobed stores and loads");

        for (int t = 5; t < 5 + N_SAME_SET; t++) begin
            issue(1'b1, make_addr(t, 20, 0), 8'hff, {next_rand(), next_rand()});
        end
        end_test("dirty eviction");

        random_burst(N_PRESSURE, 8);
        end_test("memory back-pressure");

        for (int t = 1; t <= N_CLEAN; t++) begin
            issue(1'b0, make_addr(t, 40, 0), '0, '0);
        end
        end_test("clean and invalid victims");

        $display("%0d tests run, %0d failed, %0d failing checks",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/dcache_pkg.sv
design/cache_way.sv
design/dcache_ctrl.sv
design/load_select.sv
design/dcache_top.sv
sim/dcache_sva.sv
sim/dcache_tb.sv
